/* common/decode_consts.svh */
`ifndef DECODE_CONSTS_SVH
`define DECODE_CONSTS_SVH

// Datapath width of the RV32I core
`define XLEN 32

// Major opcodes in instruction bits 6:0

// U format
`define OP_LUI      7'b0110111
`define OP_AUIPC    7'b0010111

// Jumps
`define OP_JAL      7'b1101111
`define OP_JALR     7'b1100111

// Conditional branches in B format
`define OP_BRANCH   7'b1100011

// Memory access
`define OP_LOAD     7'b0000011
`define OP_STORE    7'b0100011

// ALU with immediate or register operand
`define OP_OP_IMM   7'b0010011
`define OP_OP       7'b0110011

// FENCE and friends
`define OP_MISC_MEM 7'b0001111

// ECALL, EBREAK, CSR access
`define OP_SYSTEM   7'b1110011

`endif

/* common/decode_pkg.sv */
`default_nettype none

`include "decode_consts.svh"

package decode_pkg;

    // PC of an instruction
    typedef logic [`XLEN-1:0] addr_t;

    // Raw instruction word and immediates
    typedef logic [`XLEN-1:0] word_t;

    // Major opcode
    typedef logic [6:0] opcode_t;

    // rd, rs1, rs2
    typedef logic [4:0] reg_idx_t;

    // Function fields
    typedef logic [2:0] funct3_t;
    typedef logic [6:0] funct7_t;

    // CSR number from instr[31:20]
    typedef logic [11:0] csr_addr_t;

endpackage

`default_nettype wire

/* decode/decode_1st.sv */
`timescale 1ns/1ps
`default_nettype none

`include "decode_consts.svh"

module decode_1st (
    input  wire logic                  CLK,
    input  wire logic                  rst_n,
    input  wire logic                  flush,
    input  wire logic                  stall,
    input  wire logic                  mem_wait,

    input  wire logic                  fetch_valid,
    input  wire decode_pkg::addr_t     fetch_pc,
    input  wire decode_pkg::word_t     fetch_instr,

    output logic                       d1_valid,
    output decode_pkg::addr_t          d1_pc,
    output decode_pkg::opcode_t        d1_opcode,
    output decode_pkg::reg_idx_t       d1_rd,
    output decode_pkg::reg_idx_t       d1_rs1,
    output decode_pkg::reg_idx_t       d1_rs2,
    output decode_pkg::funct3_t        d1_funct3,
    output decode_pkg::funct7_t        d1_funct7,
    output decode_pkg::word_t          d1_imm_i,
    output decode_pkg::word_t          d1_imm_s,
    output decode_pkg::word_t          d1_imm_b,
    output decode_pkg::word_t          d1_imm_u,
    output decode_pkg::word_t          d1_imm_j
);

    logic              valid_q;
    decode_pkg::addr_t pc_q;
    decode_pkg::word_t instr_q;
    logic              hold;
    logic              sign;

    assign hold = stall | mem_wait;

    // Flush beats hold
    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
            pc_q    <= '0;
            instr_q <= '0;
        end else if (flush) begin
            valid_q <= 1'b0;
            pc_q    <= '0;
            instr_q <= '0;
        end else if (!hold) begin
            valid_q <= fetch_valid;
            pc_q    <= fetch_pc;
            instr_q <= fetch_instr;
        end
    end

    assign d1_valid  = valid_q;
    assign d1_pc     = pc_q;

    // Fixed field positions
    assign d1_opcode = instr_q[6:0];
    assign d1_rd     = instr_q[11:7];
    assign d1_funct3 = instr_q[14:12];
    assign d1_rs1    = instr_q[19:15];
    assign d1_rs2    = instr_q[24:20];
    assign d1_funct7 = instr_q[31:25];

    // All immediates sign from bit 31
    assign sign = instr_q[31];

    assign d1_imm_i = {{(`XLEN-12){sign}}, instr_q[31:20]};

    assign d1_imm_s = {{(`XLEN-12){sign}}, instr_q[31:25], instr_q[11:7]};

    // Branch offsets are halfword aligned
    assign d1_imm_b = {{(`XLEN-13){sign}}, sign, instr_q[7], instr_q[30:25],
                       instr_q[11:8], 1'b0};

    assign d1_imm_u = {instr_q[31:12], 12'b0};

    assign d1_imm_j = {{(`XLEN-21){sign}}, sign, instr_q[19:12], instr_q[20],
                       instr_q[30:21], 1'b0};

    // A flushed slot never leaves as a valid instruction
    a_flush_kills_valid : assert property (
        @(posedge CLK) disable iff (!rst_n)
        flush |=> !d1_valid
    );

endmodule

`default_nettype wire

/* decode/decode_2nd.sv */
`timescale 1ns/1ps
`default_nettype none

`include "decode_consts.svh"

module decode_2nd (
    input  wire logic                  CLK,
    input  wire logic                  rst_n,
    input  wire logic                  flush,
    input  wire logic                  stall,
    input  wire logic                  mem_wait,

    input  wire logic                  d1_valid,
    input  wire decode_pkg::addr_t     d1_pc,
    input  wire decode_pkg::opcode_t   d1_opcode,
    input  wire decode_pkg::reg_idx_t  d1_rd,
    input  wire decode_pkg::reg_idx_t  d1_rs1,
    input  wire decode_pkg::reg_idx_t  d1_rs2,
    input  wire decode_pkg::funct3_t   d1_funct3,
    input  wire decode_pkg::funct7_t   d1_funct7,
    input  wire decode_pkg::word_t     d1_imm_i,
    input  wire decode_pkg::word_t     d1_imm_s,
    input  wire decode_pkg::word_t     d1_imm_b,
    input  wire decode_pkg::word_t     d1_imm_u,
    input  wire decode_pkg::word_t     d1_imm_j,

    output logic                       decode_valid,
    output decode_pkg::addr_t          decode_pc,
    output decode_pkg::opcode_t        decode_opcode,
    output decode_pkg::reg_idx_t       decode_rd,
    output decode_pkg::reg_idx_t       decode_rs1,
    output decode_pkg::reg_idx_t       decode_rs2,
    output decode_pkg::csr_addr_t      decode_csr,
    output decode_pkg::funct3_t        decode_funct3,
    output decode_pkg::funct7_t        decode_funct7,
    output decode_pkg::word_t          decode_imm
);

    logic                 valid_q;
    decode_pkg::addr_t    pc_q;
    decode_pkg::opcode_t  opcode_q;
    decode_pkg::reg_idx_t rd_q;
    decode_pkg::reg_idx_t rs1_q;
    decode_pkg::reg_idx_t rs2_q;
    decode_pkg::funct3_t  funct3_q;
    decode_pkg::funct7_t  funct7_q;
    decode_pkg::word_t    imm_i_q;
    decode_pkg::word_t    imm_s_q;
    decode_pkg::word_t    imm_b_q;
    decode_pkg::word_t    imm_u_q;
    decode_pkg::word_t    imm_j_q;

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            valid_q  <= 1'b0;
            pc_q     <= '0;
            opcode_q <= '0;
            rd_q     <= '0;
            rs1_q    <= '0;
            rs2_q    <= '0;
            funct3_q <= '0;
            funct7_q <= '0;
            imm_i_q  <= '0;
            imm_s_q  <= '0;
            imm_b_q  <= '0;
            imm_u_q  <= '0;
            imm_j_q  <= '0;
        end else if (flush) begin
            valid_q  <= 1'b0;
            pc_q     <= '0;
            opcode_q <= '0;
            rd_q     <= '0;
            rs1_q    <= '0;
            rs2_q    <= '0;
            funct3_q <= '0;
            funct7_q <= '0;
            imm_i_q  <= '0;
            imm_s_q  <= '0;
            imm_b_q  <= '0;
            imm_u_q  <= '0;
            imm_j_q  <= '0;
        end else if (!(stall || mem_wait)) begin
            valid_q  <= d1_valid;
            pc_q     <= d1_pc;
            opcode_q <= d1_opcode;
            rd_q     <= d1_rd;
            rs1_q    <= d1_rs1;
            rs2_q    <= d1_rs2;
            funct3_q <= d1_funct3;
            funct7_q <= d1_funct7;
            imm_i_q  <= d1_imm_i;
            imm_s_q  <= d1_imm_s;
            imm_b_q  <= d1_imm_b;
            imm_u_q  <= d1_imm_u;
            imm_j_q  <= d1_imm_j;
        end
    end

    assign decode_valid  = valid_q;
    assign decode_pc     = pc_q;
    assign decode_opcode = opcode_q;
    assign decode_rd     = rd_q;
    assign decode_rs1    = rs1_q;
    assign decode_rs2    = rs2_q;
    assign decode_funct3 = funct3_q;
    assign decode_funct7 = funct7_q;

    // CSR number sits where the I immediate is
    assign decode_csr    = imm_i_q[11:0];

    // Immediate by instruction format
    always_comb begin
        case (opcode_q)
            `OP_OP:                 decode_imm = '0;
            `OP_JALR, `OP_LOAD, `OP_OP_IMM,
            `OP_MISC_MEM, `OP_SYSTEM: decode_imm = imm_i_q;
            `OP_STORE:              decode_imm = imm_s_q;
            `OP_BRANCH:             decode_imm = imm_b_q;
            `OP_LUI, `OP_AUIPC:     decode_imm = imm_u_q;
            `OP_JAL:                decode_imm = imm_j_q;
            default:                decode_imm = '0;
        endcase
    end

    a_hold_keeps_valid : assert property (
        @(posedge CLK) disable iff (!rst_n)
        (stall || mem_wait) && !flush |=> $stable(decode_valid)
    );

    a_valid_opcode_known : assert property (
        @(posedge CLK) disable iff (!rst_n)
        decode_valid |-> !$isunknown(decode_opcode)
    );

endmodule

`default_nettype wire

/* logic/decode_front.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_front (
    input  wire logic                  CLK,
    input  wire logic                  rst_n,
    input  wire logic                  flush,
    input  wire logic                  stall,
    input  wire logic                  mem_wait,

    input  wire logic                  fetch_valid,
    input  wire decode_pkg::addr_t     fetch_pc,
    input  wire decode_pkg::word_t     fetch_instr,

    output logic                       decode_valid,
    output decode_pkg::addr_t          decode_pc,
    output decode_pkg::opcode_t        decode_opcode,
    output decode_pkg::reg_idx_t       decode_rd,
    output decode_pkg::reg_idx_t       decode_rs1,
    output decode_pkg::reg_idx_t       decode_rs2,
    output decode_pkg::csr_addr_t      decode_csr,
    output decode_pkg::funct3_t        decode_funct3,
    output decode_pkg::funct7_t        decode_funct7,
    output decode_pkg::word_t          decode_imm
);

    // Stage 1 to stage 2
    logic                 d1_valid;
    decode_pkg::addr_t    d1_pc;
    decode_pkg::opcode_t  d1_opcode;
    decode_pkg::reg_idx_t d1_rd;
    decode_pkg::reg_idx_t d1_rs1;
    decode_pkg::reg_idx_t d1_rs2;
    decode_pkg::funct3_t  d1_funct3;
    decode_pkg::funct7_t  d1_funct7;
    decode_pkg::word_t    d1_imm_i;
    decode_pkg::word_t    d1_imm_s;
    decode_pkg::word_t    d1_imm_b;
    decode_pkg::word_t    d1_imm_u;
    decode_pkg::word_t    d1_imm_j;

    decode_1st i_decode_1st (
        .CLK, .rst_n, .flush, .stall, .mem_wait,
        .fetch_valid, .fetch_pc, .fetch_instr,
        .d1_valid, .d1_pc, .d1_opcode,
        .d1_rd, .d1_rs1, .d1_rs2,
        .d1_funct3, .d1_funct7,
        .d1_imm_i, .d1_imm_s, .d1_imm_b, .d1_imm_u, .d1_imm_j
    );

    decode_2nd i_decode_2nd (
        .CLK, .rst_n, .flush, .stall, .mem_wait,
        .d1_valid, .d1_pc, .d1_opcode,
        .d1_rd, .d1_rs1, .d1_rs2,
        .d1_funct3, .d1_funct7,
        .d1_imm_i, .d1_imm_s, .d1_imm_b, .d1_imm_u, .d1_imm_j,
        .decode_valid, .decode_pc, .decode_opcode,
        .decode_rd, .decode_rs1, .decode_rs2,
        .decode_csr, .decode_funct3, .decode_funct7,
        .decode_imm
    );

endmodule

`default_nettype wire

/* test/tb_decode_front.sv */
`timescale 1ns/1ps
`default_nettype none

`include "decode_consts.svh"

module tb_decode_front;

    localparam int RESET_CYCLES   = 16;
    localparam int N_PER_OP       = 4;
    localparam int N_ZERO         = 4;
    // Immediate and zero tests take three cycles each, hold and flush about twenty
    localparam int TEST_CYCLES    = RESET_CYCLES + 3 * (10 * N_PER_OP + N_ZERO) + 20;
    localparam int TIMEOUT_CYCLES = TEST_CYCLES + 100;

    logic                  CLK = 1'b0;
    logic                  rst_n;
    logic                  flush;
    logic                  stall;
    logic                  mem_wait;
    logic                  fetch_valid;
    decode_pkg::addr_t     fetch_pc;
    decode_pkg::word_t     fetch_instr;

    logic                  decode_valid;
    decode_pkg::addr_t     decode_pc;
    decode_pkg::opcode_t   decode_opcode;
    decode_pkg::reg_idx_t  decode_rd;
    decode_pkg::reg_idx_t  decode_rs1;
    decode_pkg::reg_idx_t  decode_rs2;
    decode_pkg::csr_addr_t decode_csr;
    decode_pkg::funct3_t   decode_funct3;
    decode_pkg::funct7_t   decode_funct7;
    decode_pkg::word_t     decode_imm;

    logic [15:0] lfsr_state = 16'd83;
    int          cycle_count = 0;

    logic [6:0] imm_ops [10] = '{`OP_LUI, `OP_AUIPC, `OP_JAL, `OP_JALR, `OP_BRANCH,
                                 `OP_LOAD, `OP_STORE, `OP_OP_IMM, `OP_MISC_MEM, `OP_SYSTEM};
    logic [6:0] zero_ops [N_ZERO] = '{`OP_OP, `OP_OP, 7'b1111111, 7'b1010111};

    decode_front i_dut (
        .CLK, .rst_n, .flush, .stall, .mem_wait,
        .fetch_valid, .fetch_pc, .fetch_instr,
        .decode_valid, .decode_pc, .decode_opcode,
        .decode_rd, .decode_rs1, .decode_rs2,
        .decode_csr, .decode_funct3, .decode_funct7,
        .decode_imm
    );

    always #50 CLK = ~CLK;

    always @(posedge CLK) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("STATUS: FAIL");
            $fatal(1, "run stopped by timeout");
        end
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] v);
        int i;
        v = '0;
        for (i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    // Expected immediate from the RV32I encoding of each format
    function automatic logic [31:0] ref_imm(input logic [31:0] w);
        case (w[6:0])
            `OP_JALR, `OP_LOAD, `OP_OP_IMM, `OP_MISC_MEM, `OP_SYSTEM:
                return {{20{w[31]}}, w[31:20]};
            `OP_STORE:
                return {{20{w[31]}}, w[31:25], w[11:7]};
            `OP_BRANCH:
                return {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            `OP_LUI, `OP_AUIPC:
                return {w[31:12], 12'h000};
            `OP_JAL:
                return {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            default:
                return 32'h0;
        endcase
    endfunction

    task automatic check_eq(input logic [31:0] actual, input logic [31:0] expected,
                            input string msg);
        if (actual !== expected) begin
            $display("FAILED at %0t ns: %s: got %h, expected %h", $time, msg, actual,
                     expected);
            $display("STATUS: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic check_decode(input logic [31:0] pc, input logic [31:0] instr,
                                input string tag);
        check_eq(decode_valid, 1'b1, {tag, " valid"});
        check_eq(decode_pc, pc, {tag, " pc"});
        check_eq(decode_opcode, instr[6:0], {tag, " opcode"});
        check_eq(decode_rd, instr[11:7], {tag, " rd"});
        check_eq(decode_funct3, instr[14:12], {tag, " funct3"});
        check_eq(decode_rs1, instr[19:15], {tag, " rs1"});
        check_eq(decode_rs2, instr[24:20], {tag, " rs2"});
        check_eq(decode_funct7, instr[31:25], {tag, " funct7"});
        check_eq(decode_csr, instr[31:20], {tag, " csr"});
        check_eq(decode_imm, ref_imm(instr), {tag, " imm"});
    endtask

    task automatic check_bubble(input string tag);
        check_eq(decode_valid, 1'b0, {tag, " valid"});
        check_eq(decode_pc, '0, {tag, " pc"});
        check_eq(decode_opcode, '0, {tag, " opcode"});
        check_eq(decode_rd, '0, {tag, " rd"});
        check_eq(decode_rs1, '0, {tag, " rs1"});
        check_eq(decode_rs2, '0, {tag, " rs2"});
        check_eq(decode_csr, '0, {tag, " csr"});
        check_eq(decode_funct3, '0, {tag, " funct3"});
        check_eq(decode_funct7, '0, {tag, " funct7"});
        check_eq(decode_imm, '0, {tag, " imm"});
    endtask

    task automatic drive_instr(input logic [31:0] pc, input logic [31:0] instr);
        fetch_valid = 1'b1;
        fetch_pc    = pc;
        fetch_instr = instr;
    endtask

    task automatic drive_idle();
        fetch_valid = 1'b0;
        fetch_pc    = '0;
        fetch_instr = '0;
    endtask

    task automatic make_instr(input logic [6:0] op, input int sign_mode,
                              output logic [31:0] pc, output logic [31:0] instr);
        logic [31:0] r;
        rand_bits(25, r);
        instr = {r[24:0], op};
        // Force both signs so negative immediates are always covered
        if (sign_mode == 0)
            instr[31] = 1'b1;
        else if (sign_mode == 1)
            instr[31] = 1'b0;
        rand_bits(30, r);
        pc = {r[29:0], 2'b00};
    endtask

    task automatic send_and_check(input logic [31:0] pc, input logic [31:0] instr,
                                  input string tag);
        @(negedge CLK);
        drive_instr(pc, instr);
        @(negedge CLK);
        drive_idle();
        @(negedge CLK);
        check_decode(pc, instr, tag);
    endtask

    task automatic test_reset_state();
        @(negedge CLK);
        check_bubble("reset");
    endtask

    task automatic test_immediates();
        logic [31:0] pc;
        logic [31:0] instr;
        int          op;
        int          n;
        for (op = 0; op < 10; op++) begin
            for (n = 0; n < N_PER_OP; n++) begin
                make_instr(imm_ops[op], n, pc, instr);
                send_and_check(pc, instr, $sformatf("opcode %b #%0d", imm_ops[op], n));
            end
        end
    endtask

    task automatic test_zero_imm();
        logic [31:0] pc;
        logic [31:0] instr;
        int          n;
        for (n = 0; n < N_ZERO; n++) begin
            make_instr(zero_ops[n], n, pc, instr);
            send_and_check(pc, instr, $sformatf("zero imm #%0d", n));
            check_eq(decode_imm, 32'h0, "zero imm value");
        end
    endtask

    task automatic test_hold();
        logic [31:0] pc_a;
        logic [31:0] pc_b;
        logic [31:0] instr_a;
        logic [31:0] instr_b;
        make_instr(`OP_LOAD, 0, pc_a, instr_a);
        make_instr(`OP_BRANCH, 0, pc_b, instr_b);
        @(negedge CLK);
        drive_instr(pc_a, instr_a);
        @(negedge CLK);
        drive_instr(pc_b, instr_b);
        @(negedge CLK);
        drive_idle();
        check_decode(pc_a, instr_a, "hold first");
        stall = 1'b1;
        repeat (3) begin
            @(negedge CLK);
            check_decode(pc_a, instr_a, "during stall");
        end
        stall    = 1'b0;
        mem_wait = 1'b1;
        repeat (2) begin
            @(negedge CLK);
            check_decode(pc_a, instr_a, "during mem_wait");
        end
        mem_wait = 1'b0;
        @(negedge CLK);
        check_decode(pc_b, instr_b, "hold second");
        @(negedge CLK);
        check_eq(decode_valid, 1'b0, "after hold valid");
    endtask

    task automatic test_flush();
        logic [31:0] pc;
        logic [31:0] instr;
        make_instr(`OP_JAL, 0, pc, instr);
        @(negedge CLK);
        drive_instr(pc, instr);
        make_instr(`OP_STORE, 1, pc, instr);
        @(negedge CLK);
        drive_instr(pc, instr);
        @(negedge CLK);
        drive_idle();
        flush = 1'b1;
        @(negedge CLK);
        flush = 1'b0;
        check_bubble("flush");
        // Second instruction must be gone from stage 1 as well
        @(negedge CLK);
        check_eq(decode_valid, 1'b0, "flushed stage 1 valid");
        make_instr(`OP_AUIPC, 0, pc, instr);
        send_and_check(pc, instr, "after flush");
    endtask

    initial begin
        rst_n    = 1'b0;
        flush    = 1'b0;
        stall    = 1'b0;
        mem_wait = 1'b0;
        drive_idle();
        repeat (RESET_CYCLES) @(posedge CLK);
        @(negedge CLK);
        rst_n = 1'b1;

        test_reset_state();
        test_immediates();
        test_zero_imm();
        test_hold();
        test_flush();

        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* decode_front.f */
+incdir+common
common/decode_pkg.sv
decode/decode_1st.sv
decode/decode_2nd.sv
logic/decode_front.sv
test/tb_decode_front.sv
